// File: host_io.f
source/host_io_pkg.sv
source/host_word_frontend.sv
source/host_cmd_regs.sv
source/file_loader.sv
source/ps2_clk_div.sv
source/ps2_device.sv
source/host_io_top.sv
tests/host_io_checker.sv
tests/tb_host_io.sv

// File: Bender.yml
package:
  name: host_io

sources:
  - source/host_io_pkg.sv
  - source/host_word_frontend.sv
  - source/host_cmd_regs.sv
  - source/file_loader.sv
  - source/ps2_clk_div.sv
  - source/ps2_device.sv
  - source/host_io_top.sv
  - target: test
    files:
      - tests/host_io_checker.sv
      - tests/tb_host_io.sv

// File: tests/tb_host_io.sv
// testbench top for the host command bridge
// drives host transactions on the transfer bus; host_io_checker sits
// beside the DUT, models it and does all comparing

`timescale 1ns/1ps

module tb_host_io;
	import host_io_pkg::*;

	localparam int TOTAL_WORDS     = 70;
	localparam int PS2_BYTES       = 9;
	localparam int PS2_BIT_CYCLES  = 2 * (PS2_DIV + 1);
	localparam int IDLE_CYCLES     = 30 * PS2_BIT_CYCLES;
	localparam int WATCHDOG_CYCLES = 2 * (TOTAL_WORDS * 4 + 11 * PS2_BIT_CYCLES * (PS2_BYTES + 4))
		+ 2 * IDLE_CYCLES + 20;

	logic                       clk_sys;
	logic                       rst;
	logic                       io_enable;
	logic                       io_strobe;
	logic [15:0]                io_din;
	logic [15:0]                io_dout;
	logic                       io_wait;
	logic                       ioctl_wait;
	logic [8*CONF_STRLEN-1:0]   conf_str;
	logic [31:0]                status_in;
	logic                       status_set;
	logic [1:0]                 buttons;
	logic                       forced_scandoubler;
	logic [31:0]                joystick_0;
	logic [31:0]                joystick_1;
	logic [31:0]                status;
	ioctl_t                     ioctl;
	logic                       ioctl_wr;
	logic                       ioctl_download;
	logic [31:0]                ioctl_file_ext;
	logic                       ps2_kbd_clk_out;
	logic                       ps2_kbd_data_out;
	logic                       ps2_mouse_clk_out;
	logic                       ps2_mouse_data_out;
	int                         check_count;
	int                         error_count;
	int                         pending;
	int                         err_base;
	int                         seed = 70;
	logic [15:0]                arg_buf [0:31];

	host_io_top uut (
		.clk_sys(clk_sys), .rst(rst), .io_enable(io_enable), .io_strobe(io_strobe),
		.io_din(io_din), .io_dout(io_dout), .io_wait(io_wait), .ioctl_wait(ioctl_wait),
		.conf_str(conf_str), .status_in(status_in), .status_set(status_set),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .status(status),
		.ioctl(ioctl), .ioctl_wr(ioctl_wr), .ioctl_download(ioctl_download),
		.ioctl_file_ext(ioctl_file_ext), .ps2_kbd_clk_out(ps2_kbd_clk_out),
		.ps2_kbd_data_out(ps2_kbd_data_out), .ps2_mouse_clk_out(ps2_mouse_clk_out),
		.ps2_mouse_data_out(ps2_mouse_data_out)
	);

	host_io_checker chk (
		.clk_sys(clk_sys), .rst(rst), .io_enable(io_enable), .io_strobe(io_strobe),
		.io_din(io_din), .io_dout(io_dout), .io_wait(io_wait), .ioctl_wait(ioctl_wait),
		.conf_str(conf_str), .status_in(status_in),
		.status_set(status_set), .buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .status(status),
		.ioctl(ioctl), .ioctl_wr(ioctl_wr), .ioctl_download(ioctl_download),
		.ioctl_file_ext(ioctl_file_ext),
		.ps2_clk({ps2_mouse_clk_out, ps2_kbd_clk_out}),
		.ps2_dat({ps2_mouse_data_out, ps2_kbd_data_out}),
		.check_count(check_count), .error_count(error_count), .pending(pending)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	////////////////////
	// host bus stimulus
	function automatic logic [15:0] rand_word();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// one strobe that leaves the next one 3 cycles later
	task automatic strobe_word(input logic [15:0] d);
		@(negedge clk_sys);
		while (io_wait) @(negedge clk_sys);
		io_din = d;
		io_strobe = 1'b1;
		@(negedge clk_sys);
		io_strobe = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic send_txn(input logic [15:0] cmd, input int n);
		@(negedge clk_sys);
		io_enable = 1'b1;
		strobe_word(cmd);
		for (int i = 0; i < n; i++) strobe_word(arg_buf[i]);
		// last answer settles before enable drops
		repeat (2) @(negedge clk_sys);
		io_enable = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic pulse_status_set();
		logic [31:0] r;
		@(negedge clk_sys);
		r = $random(seed);
		status_in = r;
		status_set = 1'b1;
		repeat (2) @(negedge clk_sys);
		status_set = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	// the loader side holds the host off for a few cycles
	task automatic hold_ioctl_wait(input int cycles);
		@(negedge clk_sys);
		ioctl_wait = 1'b1;
		repeat (cycles) @(negedge clk_sys);
		ioctl_wait = 1'b0;
	endtask

	// waits for all queued frames and then a quiet time that catches stray ones
	task automatic wait_frames();
		wait (pending == 0);
		repeat (IDLE_CYCLES) @(negedge clk_sys);
	endtask

	task automatic end_test(input string name);
		if (error_count == err_base) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, error_count - err_base);
		err_base = error_count;
	endtask

	initial begin
		io_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		ioctl_wait = 1'b0;
		conf_str = "HOSTIO01";
		status_in = '0;
		status_set = 1'b0;
		err_base = 0;
		rst = 1'b1;
		repeat (10) @(negedge clk_sys);
		rst = 1'b0;

		arg_buf[0] = rand_word();
		send_txn(CMD_CFG, 1);
		for (int i = 0; i < 2; i++) arg_buf[i] = rand_word();
		send_txn(CMD_JOY0, 2);
		for (int i = 0; i < 2; i++) arg_buf[i] = rand_word();
		send_txn(CMD_JOY1, 2);
		end_test("configuration and joysticks");

		for (int i = 0; i < 2; i++) arg_buf[i] = rand_word();
		send_txn(CMD_STATUS, 2);
		pulse_status_set();
		pulse_status_set();
		for (int i = 0; i < 2; i++) arg_buf[i] = '0;
		send_txn(CMD_STATUS_REQ, 2);
		end_test("status and status request");

		// two slots past the end of the string
		for (int i = 0; i < CONF_STRLEN + 2; i++) arg_buf[i] = '0;
		send_txn(CMD_CONF_STR, CONF_STRLEN + 2);
		end_test("config string readback");

		arg_buf[0] = rand_word() & 16'h00FF;
		send_txn(CMD_FILE_INDEX, 1);
		for (int i = 0; i < 2; i++) arg_buf[i] = rand_word();
		send_txn(CMD_FILE_INFO, 2);
		arg_buf[0] = 16'h0001;
		send_txn(CMD_FILE_TX, 1);
		hold_ioctl_wait(4);
		for (int i = 0; i < 20; i++) arg_buf[i] = rand_word();
		send_txn(CMD_FILE_TX_DAT, 20);
		arg_buf[0] = 16'h0000;
		send_txn(CMD_FILE_TX, 1);
		end_test("file download");

		for (int i = 0; i < 4; i++) arg_buf[i] = rand_word() & 16'h00FF;
		send_txn(CMD_KBD, 4);
		for (int i = 0; i < 3; i++) arg_buf[i] = rand_word() & 16'h00FF;
		send_txn(CMD_MOUSE, 3);
		wait_frames();
		end_test("keyboard and mouse frames");

		for (int i = 0; i < 5; i++) arg_buf[i] = rand_word() & 16'h00FF;
		arg_buf[2] = arg_buf[2] | 16'hFF00;
		send_txn(CMD_MOUSE, 5);
		wait_frames();
		end_test("mouse skip after FF word");

		$display("6 tests, %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: tests/host_io_checker.sv
// checker for the host command bridge testbench
// rebuilds the expected bridge state from the bus traffic it sees and
// compares registers, readback words, the ioctl stream and ps/2 frames

`timescale 1ns/1ps

module host_io_checker (
	input  logic                                  clk_sys,
	input  logic                                  rst,
	input  logic                                  io_enable,
	input  logic                                  io_strobe,
	input  logic [15:0]                           io_din,
	input  logic [15:0]                           io_dout,
	input  logic                                  io_wait,
	input  logic                                  ioctl_wait,
	input  logic [8*host_io_pkg::CONF_STRLEN-1:0] conf_str,
	input  logic [31:0]                           status_in,
	input  logic                                  status_set,
	input  logic [1:0]                            buttons,
	input  logic                                  forced_scandoubler,
	input  logic [31:0]                           joystick_0,
	input  logic [31:0]                           joystick_1,
	input  logic [31:0]                           status,
	input  host_io_pkg::ioctl_t                   ioctl,
	input  logic                                  ioctl_wr,
	input  logic                                  ioctl_download,
	input  logic [31:0]                           ioctl_file_ext,
	input  logic [1:0]                            ps2_clk,
	input  logic [1:0]                            ps2_dat,
	output int                                    check_count,
	output int                                    error_count,
	output int                                    pending
);
	import host_io_pkg::*;

	logic [15:0] cmd;
	int          idx;
	logic        skip;
	logic        en_prev;
	logic        set_prev;
	logic [3:0]  req_cnt;
	logic [31:0] req_cap;
	logic [15:0] exp_dout;
	logic [1:0]  exp_buttons;
	logic        exp_fsd;
	logic [31:0] exp_joy0;
	logic [31:0] exp_joy1;
	logic [31:0] exp_status;
	logic [31:0] exp_ext;
	logic        ext_known;
	logic        exp_download;
	logic [7:0]  exp_index;
	logic [24:0] exp_addr;
	ioctl_t      write_q[$];
	logic [7:0]  kbd_q[$];
	logic [7:0]  mouse_q[$];
	logic [1:0]  clk_prev;
	logic [10:0] frame [2];
	int          nbits [2];

	////////////////////
	// reference functions

	// frame as received with the start bit in bit 0 and the stop bit on top
	function automatic logic [10:0] frame_bits(input logic [7:0] b);
		return {1'b1, ~^b, b, 1'b0};
	endfunction

	// character n of the string counted from the left or zero outside it
	function automatic logic [7:0] conf_char(input logic [8*CONF_STRLEN-1:0] s, input int n);
		logic [8*CONF_STRLEN-1:0] shifted;
		if (n < 1 || n > CONF_STRLEN) return 8'h00;
		shifted = s << (8 * (n - 1));
		return shifted[8*CONF_STRLEN-1 -: 8];
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	////////////////////
	// bus side model
	task automatic take_word(input logic [15:0] d);
		if (idx == 0) begin
			cmd = d;
			exp_dout = (d == CMD_STATUS_REQ) ? {8'h00, STATUS_REQ_TAG, req_cnt} : 16'h0000;
		end else begin
			exp_dout = 16'h0000;
			case (cmd)
				CMD_CFG: begin
					exp_buttons = d[1:0];
					exp_fsd = d[4];
				end
				CMD_JOY0: begin
					if (idx == 1) exp_joy0[15:0] = d;
					else exp_joy0[31:16] = d;
				end
				CMD_JOY1: begin
					if (idx == 1) exp_joy1[15:0] = d;
					else exp_joy1[31:16] = d;
				end
				CMD_STATUS: begin
					if (idx == 1) exp_status[15:0] = d;
					else if (idx == 2) exp_status[31:16] = d;
				end
				CMD_CONF_STR: exp_dout = {8'h00, conf_char(conf_str, idx)};
				CMD_STATUS_REQ: begin
					if (idx == 1) exp_dout = req_cap[15:0];
					else if (idx == 2) exp_dout = req_cap[31:16];
				end
				CMD_KBD, CMD_MOUSE: begin
					if (d[15:8] == 8'hFF) begin
						skip = 1'b1;
					end else if (!skip) begin
						if (cmd == CMD_KBD) kbd_q.push_back(d[7:0]);
						else mouse_q.push_back(d[7:0]);
						pending++;
					end
				end
				CMD_FILE_INDEX: exp_index = d[7:0];
				CMD_FILE_INFO: begin
					if (idx == 1) exp_ext[31:16] = d;
					else if (idx == 2) begin
						exp_ext[15:0] = d;
						ext_known = 1'b1;
					end
				end
				CMD_FILE_TX: begin
					exp_download = (d[7:0] != 8'h00);
					if (exp_download) exp_addr = '0;
				end
				CMD_FILE_TX_DAT: begin
					write_q.push_back({exp_index, exp_addr, d[7:0]});
					pending++;
					exp_addr = exp_addr + 25'd1;
				end
				default: ;
			endcase
		end
		if (idx < 1023) idx++;
	endtask

	task automatic compare_outputs();
		check("io_dout", io_dout, exp_dout);
		check("buttons", buttons, exp_buttons);
		check("forced_scandoubler", forced_scandoubler, exp_fsd);
		check("joystick_0", joystick_0, exp_joy0);
		check("joystick_1", joystick_1, exp_joy1);
		check("status", status, exp_status);
		check("ioctl_download", ioctl_download, exp_download);
		if (ext_known) check("ioctl_file_ext", ioctl_file_ext, exp_ext);
	endtask

	task automatic check_write();
		ioctl_t exp_w;
		if (write_q.size() == 0) begin
			error_count++;
			$display("[ERROR] %0t: ioctl write seen without a data word for it", $time);
		end else begin
			exp_w = write_q.pop_front();
			pending--;
			check("ioctl index", ioctl.index, exp_w.index);
			check("ioctl addr", ioctl.addr, exp_w.addr);
			check("ioctl data", ioctl.data, exp_w.data);
			check("ioctl_download during write", ioctl_download, 1'b1);
		end
	endtask

	// register side and ioctl checks on the rising edge
	always @(posedge clk_sys) begin
		if (rst) begin
			idx = 0;
			skip = 1'b0;
			en_prev = 1'b0;
			set_prev = 1'b0;
			req_cnt = '0;
			exp_dout = '0;
			exp_buttons = '0;
			exp_fsd = 1'b0;
			exp_joy0 = '0;
			exp_joy1 = '0;
			exp_status = '0;
			ext_known = 1'b0;
			exp_download = 1'b0;
			exp_index = '0;
			exp_addr = '0;
		end else begin
			// the host sees the loader's wait line unchanged
			check("io_wait", io_wait, ioctl_wait);
			if (status_set && !set_prev) begin
				req_cnt = req_cnt + 4'd1;
				req_cap = status_in;
			end
			set_prev = status_set;
			if (ioctl_wr) check_write();
			if (io_enable && io_strobe) begin
				compare_outputs();
				take_word(io_din);
			end else if (!io_enable && en_prev) begin
				compare_outputs();
				// readback clears and a new transaction starts over
				exp_dout = '0;
				skip = 1'b0;
				idx = 0;
			end
			en_prev = io_enable;
		end
	end

	////////////////////
	// ps/2 frame capture where the device clock falls
	task automatic frame_bit(input int dev, input logic b);
		logic [7:0] exp_b;
		frame[dev] = {b, frame[dev][10:1]};
		nbits[dev]++;
		if (nbits[dev] == 11) begin
			nbits[dev] = 0;
			if ((dev == 0 && kbd_q.size() == 0) || (dev == 1 && mouse_q.size() == 0)) begin
				error_count++;
				$display("[ERROR] %0t: %s sent a frame that was never queued", $time,
					dev == 0 ? "keyboard" : "mouse");
			end else begin
				if (dev == 0) exp_b = kbd_q.pop_front();
				else exp_b = mouse_q.pop_front();
				pending--;
				check(dev == 0 ? "keyboard frame" : "mouse frame", frame[dev], frame_bits(exp_b));
			end
		end
	endtask

	always @(negedge clk_sys) begin
		if (rst) begin
			clk_prev = 2'b11;
			nbits[0] = 0;
			nbits[1] = 0;
		end else begin
			for (int dev = 0; dev < 2; dev++) begin
				if (clk_prev[dev] && !ps2_clk[dev]) frame_bit(dev, ps2_dat[dev]);
			end
			clk_prev = ps2_clk;
		end
	end

endmodule

// File: source/host_io_top.sv
// top level of the host command bridge
// connects the bus front end to the register block and download channel
// and drives the emulated keyboard and mouse from one ps/2 clock

`timescale 1ns/1ps

module host_io_top (
	input  logic                                  clk_sys,
	input  logic                                  rst,
	input  logic                                  io_enable,
	input  logic                                  io_strobe,
	input  logic [15:0]                           io_din,
	output logic [15:0]                           io_dout,
	output logic                                  io_wait,
	input  logic                                  ioctl_wait,
	input  logic [8*host_io_pkg::CONF_STRLEN-1:0] conf_str,
	input  logic [31:0]                           status_in,
	input  logic                                  status_set,
	output logic [1:0]                            buttons,
	output logic                                  forced_scandoubler,
	output logic [31:0]                           joystick_0,
	output logic [31:0]                           joystick_1,
	output logic [31:0]                           status,
	output host_io_pkg::ioctl_t                   ioctl,
	output logic                                  ioctl_wr,
	output logic                                  ioctl_download,
	output logic [31:0]                           ioctl_file_ext,
	output logic                                  ps2_kbd_clk_out,
	output logic                                  ps2_kbd_data_out,
	output logic                                  ps2_mouse_clk_out,
	output logic                                  ps2_mouse_data_out
);
	import host_io_pkg::*;

	host_word_t word;
	logic       word_valid;
	ps2_byte_t  kbd_byte;
	ps2_byte_t  mouse_byte;
	logic       ps2_clk_level;
	logic       ps2_tick;

	// download back-pressure is the only wait source
	assign io_wait = ioctl_wait;

	host_word_frontend u_frontend (
		.clk_sys(clk_sys), .rst(rst), .io_enable(io_enable), .io_strobe(io_strobe),
		.io_din(io_din), .word(word), .word_valid(word_valid)
	);

	host_cmd_regs u_regs (
		.clk_sys(clk_sys), .rst(rst), .io_enable(io_enable), .word(word),
		.word_valid(word_valid), .conf_str(conf_str), .status_in(status_in),
		.status_set(status_set), .io_dout(io_dout), .buttons(buttons),
		.forced_scandoubler(forced_scandoubler), .joystick_0(joystick_0),
		.joystick_1(joystick_1), .status(status), .kbd_byte(kbd_byte),
		.mouse_byte(mouse_byte)
	);

	file_loader u_loader (
		.clk_sys(clk_sys), .rst(rst), .word(word), .word_valid(word_valid),
		.ioctl(ioctl), .ioctl_wr(ioctl_wr), .ioctl_download(ioctl_download),
		.ioctl_file_ext(ioctl_file_ext)
	);

	ps2_clk_div u_ps2_div (
		.clk_sys(clk_sys), .rst(rst), .ps2_clk_level(ps2_clk_level), .ps2_tick(ps2_tick)
	);

	ps2_device u_keyboard (
		.clk_sys(clk_sys), .rst(rst), .wbyte(kbd_byte), .ps2_clk_level(ps2_clk_level),
		.ps2_tick(ps2_tick), .ps2_clk_out(ps2_kbd_clk_out), .ps2_dat_out(ps2_kbd_data_out)
	);

	ps2_device u_mouse (
		.clk_sys(clk_sys), .rst(rst), .wbyte(mouse_byte), .ps2_clk_level(ps2_clk_level),
		.ps2_tick(ps2_tick), .ps2_clk_out(ps2_mouse_clk_out),
		.ps2_dat_out(ps2_mouse_data_out)
	);

endmodule

// File: source/ps2_device.sv
// one emulated ps/2 device, transmit side only
// bytes are queued in a small FIFO and sent as 11 bit frames
// clocked by the shared divided ps/2 clock

`timescale 1ns/1ps

module ps2_device (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  host_io_pkg::ps2_byte_t wbyte,
	input  logic                   ps2_clk_level,
	input  logic                   ps2_tick,
	output logic                   ps2_clk_out,
	output logic                   ps2_dat_out
);
	import host_io_pkg::*;

	logic [7:0] fifo [1<<PS2_FIFO_BITS];

	// one extra bit tells full from empty
	logic [PS2_FIFO_BITS:0] wptr;
	logic [PS2_FIFO_BITS:0] rptr;
	logic                   fifo_empty;
	logic                   fifo_full;

	logic       clk_rise;
	logic       clk_fall;
	logic [1:0] holdoff;
	logic [3:0] tx_state;
	logic [7:0] tx_byte;
	logic       parity;

	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[PS2_FIFO_BITS] != rptr[PS2_FIFO_BITS]) &&
		(wptr[PS2_FIFO_BITS-1:0] == rptr[PS2_FIFO_BITS-1:0]);

	assign clk_rise = ps2_tick & ps2_clk_level;
	assign clk_fall = ps2_tick & ~ps2_clk_level;

	always_ff @(posedge clk_sys) begin
		if (wbyte.valid) begin
			fifo[wptr[PS2_FIFO_BITS-1:0]] <= wbyte.data;
		end
	end

	////////////////////
	// transmitter
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wptr        <= '0;
			rptr        <= '0;
			holdoff     <= '0;
			tx_state    <= '0;
			ps2_clk_out <= 1'b1;
			ps2_dat_out <= 1'b1;
		end else begin
			if (wbyte.valid) begin
				wptr <= wptr + 1'b1;
			end

			if (clk_rise) begin
				ps2_clk_out <= 1'b1;
				if (tx_state == 4'd0) begin
					// a queued byte waits four rising edges before its frame
					if (!fifo_empty) begin
						holdoff <= holdoff + 2'd1;
						if (holdoff == 2'd3) begin
							tx_byte     <= fifo[rptr[PS2_FIFO_BITS-1:0]];
							rptr        <= rptr + 1'b1;
							parity      <= 1'b1;
							tx_state    <= 4'd1;
							ps2_dat_out <= 1'b0;
						end
					end
				end else begin
					if (tx_state <= 4'd8) begin
						// data bits go out lsb first
						ps2_dat_out  <= tx_byte[0];
						tx_byte[6:0] <= tx_byte[7:1];
						if (tx_byte[0]) parity <= ~parity;
					end
					if (tx_state == 4'd9) ps2_dat_out <= parity;
					if (tx_state == 4'd10) ps2_dat_out <= 1'b1;
					if (tx_state == 4'd11) tx_state <= 4'd0;
					else tx_state <= tx_state + 4'd1;
				end
			end

			// the clock only drops while a frame is in flight
			if (clk_fall) begin
				ps2_clk_out <= (tx_state == 4'd0);
			end
		end
	end

	a_no_push_full: assert property (@(posedge clk_sys) disable iff (rst)
		wbyte.valid |-> !fifo_full);

endmodule

// File: source/ps2_clk_div.sv
// divider for the shared ps/2 bit clock
// the level toggles every PS2_DIV+1 cycles of clk_sys and
// ps2_tick marks the first cycle of each new level

`timescale 1ns/1ps

module ps2_clk_div (
	input  logic clk_sys,
	input  logic rst,
	output logic ps2_clk_level,
	output logic ps2_tick
);
	import host_io_pkg::*;

	logic [PS2_DIV_W-1:0] div_cnt;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			div_cnt       <= '0;
			ps2_clk_level <= 1'b1;
			ps2_tick      <= 1'b0;
		end else begin
			ps2_tick <= 1'b0;
			if (div_cnt == PS2_DIV_W'(PS2_DIV)) begin
				div_cnt       <= '0;
				ps2_clk_level <= ~ps2_clk_level;
				ps2_tick      <= 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

// File: source/file_loader.sv
// file download channel
// turns index, file info, start/stop and data commands into the
// byte wide ioctl write stream, one output stage behind the decode

`timescale 1ns/1ps

module file_loader (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  host_io_pkg::host_word_t word,
	input  logic                    word_valid,
	output host_io_pkg::ioctl_t     ioctl,
	output logic                    ioctl_wr,
	output logic                    ioctl_download,
	output logic [31:0]             ioctl_file_ext
);
	import host_io_pkg::*;

	logic [24:0] addr;
	logic [24:0] wr_addr;
	logic [7:0]  wr_data;
	logic        wr;
	logic        download;

	// control path
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr             <= 1'b0;
			download       <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
		end else begin
			ioctl_wr       <= wr;
			ioctl_download <= download;
			wr             <= 1'b0;
			if (word_valid && !word.first) begin
				if (word.cmd == CMD_FILE_TX) begin
					download <= |word.data[7:0];
				end
				if (word.cmd == CMD_FILE_TX_DAT) begin
					wr <= 1'b1;
				end
			end
		end
	end

	// data path
	always_ff @(posedge clk_sys) begin
		ioctl.addr <= wr_addr;
		ioctl.data <= wr_data;
		if (word_valid && !word.first) begin
			case (word.cmd)
				CMD_FILE_INDEX: ioctl.index <= word.data[7:0];
				CMD_FILE_INFO: begin
					// extension arrives high half first
					if (word.idx == 10'd1) ioctl_file_ext[31:16] <= word.data;
					else if (word.idx == 10'd2) ioctl_file_ext[15:0] <= word.data;
				end
				CMD_FILE_TX: begin
					if (|word.data[7:0]) addr <= '0;
				end
				CMD_FILE_TX_DAT: begin
					wr_addr <= addr;
					wr_data <= word.data[7:0];
					addr    <= addr + 25'd1;
				end
				default: ;
			endcase
		end
	end

	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (rst)
		ioctl_wr |-> ioctl_download);

endmodule

// File: source/host_cmd_regs.sv
// register block behind the host front end
// holds configuration, joysticks and status, answers readback commands
// and forwards keyboard and mouse bytes to the ps/2 devices

`timescale 1ns/1ps

module host_cmd_regs (
	input  logic                                clk_sys,
	input  logic                                rst,
	input  logic                                io_enable,
	input  host_io_pkg::host_word_t             word,
	input  logic                                word_valid,
	input  logic [8*host_io_pkg::CONF_STRLEN-1:0] conf_str,
	input  logic [31:0]                         status_in,
	input  logic                                status_set,
	output logic [15:0]                         io_dout,
	output logic [1:0]                          buttons,
	output logic                                forced_scandoubler,
	output logic [31:0]                         joystick_0,
	output logic [31:0]                         joystick_1,
	output logic [31:0]                         status,
	output host_io_pkg::ps2_byte_t              kbd_byte,
	output host_io_pkg::ps2_byte_t              mouse_byte
);
	import host_io_pkg::*;

	logic        old_status_set;
	logic [3:0]  req_cnt;
	logic [31:0] status_req;
	logic        ps2_skip;
	logic        arg_word;
	logic        ff_word;

	assign arg_word = word_valid & ~word.first;
	// an upper byte of all ones ends the useful part of a ps/2 transaction
	assign ff_word  = &word.data[15:8];

	////////////////////
	// status set requests
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_status_set <= 1'b0;
			req_cnt        <= '0;
		end else begin
			old_status_set <= status_set;
			if (status_set && !old_status_set) begin
				req_cnt <= req_cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set && !old_status_set) begin
			status_req <= status_in;
		end
	end

	////////////////////
	// command decode
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			io_dout            <= '0;
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
			joystick_0         <= '0;
			joystick_1         <= '0;
			status             <= '0;
			ps2_skip           <= 1'b0;
			kbd_byte.valid     <= 1'b0;
			mouse_byte.valid   <= 1'b0;
		end else begin
			kbd_byte.valid   <= 1'b0;
			mouse_byte.valid <= 1'b0;

			if (!io_enable) begin
				io_dout  <= '0;
				ps2_skip <= 1'b0;
			end

			if (word_valid && word.first) begin
				io_dout <= '0;
				if (word.cmd == CMD_STATUS_REQ) begin
					io_dout <= {8'h00, STATUS_REQ_TAG, req_cnt};
				end
			end

			if (arg_word) begin
				io_dout <= '0;
				case (word.cmd)
					CMD_CFG: begin
						buttons            <= word.data[1:0];
						forced_scandoubler <= word.data[4];
					end
					CMD_JOY0: begin
						if (word.idx == 10'd1) joystick_0[15:0] <= word.data;
						else joystick_0[31:16] <= word.data;
					end
					CMD_JOY1: begin
						if (word.idx == 10'd1) joystick_1[15:0] <= word.data;
						else joystick_1[31:16] <= word.data;
					end
					CMD_STATUS: begin
						if (word.idx == 10'd1) status[15:0] <= word.data;
						else if (word.idx == 10'd2) status[31:16] <= word.data;
					end
					CMD_CONF_STR: begin
						// leftmost character sits in the top byte
						if (word.idx <= 10'(CONF_STRLEN)) begin
							io_dout[7:0] <= conf_str[8*(CONF_STRLEN - int'(word.idx)) +: 8];
						end
					end
					CMD_STATUS_REQ: begin
						if (word.idx == 10'd1) io_dout <= status_req[15:0];
						else if (word.idx == 10'd2) io_dout <= status_req[31:16];
					end
					CMD_KBD: begin
						if (ff_word) ps2_skip <= 1'b1;
						kbd_byte.valid <= ~ff_word & ~ps2_skip;
						kbd_byte.data  <= word.data[7:0];
					end
					CMD_MOUSE: begin
						if (ff_word) ps2_skip <= 1'b1;
						mouse_byte.valid <= ~ff_word & ~ps2_skip;
						mouse_byte.data  <= word.data[7:0];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: source/host_word_frontend.sv
// front end of the host transfer bus
// counts the words of a transaction, keeps the command word and
// hands each received word on one cycle after its strobe

`timescale 1ns/1ps

module host_word_frontend (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic                    io_enable,
	input  logic                    io_strobe,
	input  logic [15:0]             io_din,
	output host_io_pkg::host_word_t word,
	output logic                    word_valid
);
	import host_io_pkg::*;

	logic [9:0]  word_cnt;
	logic [15:0] cmd_q;
	logic        first;

	// the command is the word taken while the counter is still zero
	assign first = (word_cnt == '0);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			word_cnt   <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= io_strobe & io_enable;
			if (!io_enable) begin
				word_cnt <= '0;
			end else if (io_strobe && !(&word_cnt)) begin
				// saturates on very long transactions
				word_cnt <= word_cnt + 10'd1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (io_strobe) begin
			word.cmd   <= first ? io_din : cmd_q;
			word.idx   <= word_cnt;
			word.first <= first;
			word.data  <= io_din;
			if (first) begin
				cmd_q <= io_din;
			end
		end
	end

	// host protocol: strobes only inside a transaction
	a_strobe_in_enable: assert property (@(posedge clk_sys) disable iff (rst)
		io_strobe |-> io_enable);

endmodule

// File: source/host_io_pkg.sv
// shared definitions for the host command bridge
// command codes, sizes and the packed types passed between blocks
// every RTL module imports this package inside its body

package host_io_pkg;

	////////////////////
	// host command codes
	localparam logic [15:0] CMD_CFG         = 16'h0001;
	localparam logic [15:0] CMD_JOY0        = 16'h0002;
	localparam logic [15:0] CMD_JOY1        = 16'h0003;
	localparam logic [15:0] CMD_MOUSE       = 16'h0004;
	localparam logic [15:0] CMD_KBD         = 16'h0005;
	localparam logic [15:0] CMD_CONF_STR    = 16'h0014;
	localparam logic [15:0] CMD_STATUS      = 16'h001E;
	localparam logic [15:0] CMD_STATUS_REQ  = 16'h0029;
	localparam logic [15:0] CMD_FILE_TX     = 16'h0053;
	localparam logic [15:0] CMD_FILE_TX_DAT = 16'h0054;
	localparam logic [15:0] CMD_FILE_INDEX  = 16'h0055;
	localparam logic [15:0] CMD_FILE_INFO   = 16'h0056;

	////////////////////
	// sizes
	localparam int CONF_STRLEN   = 8;
	localparam int PS2_DIV       = 4;
	localparam int PS2_DIV_W     = $clog2(PS2_DIV + 1);
	localparam int PS2_FIFO_BITS = 4;

	// sits above the request counter in the status request answer
	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

	////////////////////
	// one decoded bus word, 43 bits
	typedef struct packed {
		logic [15:0] cmd;
		logic [9:0]  idx;
		logic        first;
		logic [15:0] data;
	} host_word_t;

	// one download write, 41 bits
	typedef struct packed {
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} ioctl_t;

	// byte pushed into a ps/2 device
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} ps2_byte_t;

endpackage
